/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_core_pkg.sv
  - src/core_sequencer.sv
  - src/inst_decoder.sv
  - src/reg_file.sv
  - src/execute_unit.sv
  - src/load_store_unit.sv
  - src/rv_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/rv_core_tb.sv

/* src.f */
+incdir+tb
src/rv_core_pkg.sv
src/core_sequencer.sv
src/inst_decoder.sv
src/reg_file.sv
src/execute_unit.sv
src/load_store_unit.sv
src/rv_core.sv
tb/rv_core_tb.sv

/* src/core_sequencer.sv */
/* Instruction sequencer: steps each instruction through fetch, execute, memory and writeback,
   owns the PC and instruction register, and publishes the retire record. */
`timescale 1ns/1ps

module core_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    // instruction memory
    output logic                   imem_req_valid,
    input  logic                   imem_req_ready,
    output rv_core_pkg::word_t     imem_addr,
    input  logic                   imem_resp_valid,
    input  rv_core_pkg::word_t     imem_resp_data,
    // decode and execute results
    input  logic                   mem_access,
    input  logic                   reg_we,
    input  rv_core_pkg::reg_addr_t rd,
    input  logic                   is_load,
    input  rv_core_pkg::word_t     exe_result,
    input  rv_core_pkg::word_t     next_pc,
    output rv_core_pkg::word_t     inst,
    output rv_core_pkg::word_t     pc,
    // load/store unit
    output logic                   mem_start,
    input  logic                   mem_done,
    input  rv_core_pkg::word_t     load_data,
    // register file write
    output logic                   wb_we,
    output rv_core_pkg::reg_addr_t wb_addr,
    output rv_core_pkg::word_t     wb_data,
    // retire record
    output logic                   retire_valid,
    output rv_core_pkg::word_t     retire_pc,
    output rv_core_pkg::reg_addr_t retire_rd,
    output logic                   retire_we,
    output rv_core_pkg::word_t     retire_wdata
);
    import rv_core_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_INST,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } seq_state_t;

    seq_state_t state, next_state;

    always_comb begin
        next_state = state;
        unique case (state)
            FETCH:     if (imem_req_valid && imem_req_ready) next_state = WAIT_INST;
            WAIT_INST: if (imem_resp_valid) next_state = EXECUTE;
            EXECUTE:   next_state = mem_access ? MEMORY : WRITEBACK;
            MEMORY:    if (mem_done) next_state = WRITEBACK;
            WRITEBACK: next_state = FETCH;
            default:   next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= FETCH;
            imem_req_valid <= 1'b0;
            pc             <= RESET_PC;
            inst           <= '0;
        end else begin
            state          <= next_state;
            imem_req_valid <= (next_state == FETCH);  // held until the fetch handshake
            if (state == WAIT_INST && imem_resp_valid)
                inst <= imem_resp_data;
            if (state == WRITEBACK)
                pc <= next_pc;
        end
    end

    // writeback value, ready before WRITEBACK
    always_ff @(posedge clk) begin
        if ((state == EXECUTE && !mem_access) || (state == MEMORY && mem_done))
            wb_data <= is_load ? load_data : exe_result;
    end

    assign imem_addr = pc;
    assign mem_start = (state == EXECUTE) && mem_access;  // one cycle pulse

    assign wb_we   = (state == WRITEBACK) && reg_we;
    assign wb_addr = rd;

    assign retire_valid = (state == WRITEBACK);
    assign retire_pc    = pc;  // pc moves on only after this cycle
    assign retire_rd    = rd;
    assign retire_we    = wb_we;
    assign retire_wdata = wb_data;

endmodule

/* src/execute_unit.sv */
/* Combinational execute stage: operand select, ALU, branch compare,
   next PC, link value and the load/store address. */
`timescale 1ns/1ps

module execute_unit (
    input  logic [6:0]           opcode,
    input  rv_core_pkg::funct3_t funct3,
    input  rv_core_pkg::alu_op_t alu_op,
    input  rv_core_pkg::word_t   pc,
    input  rv_core_pkg::word_t   imm,
    input  rv_core_pkg::word_t   rs1_data,
    input  rv_core_pkg::word_t   rs2_data,
    output rv_core_pkg::word_t   exe_result,
    output rv_core_pkg::word_t   next_pc,
    output rv_core_pkg::word_t   mem_addr
);
    import rv_core_pkg::*;

    word_t alu_a, alu_b, alu_result, link;
    logic  taken;

    // pc-relative forms take pc on A, lui adds to zero
    always_comb begin
        unique case (opcode)
            OP_AUIPC, OP_JAL, OP_BRANCH: alu_a = pc;
            OP_LUI:                      alu_a = '0;
            default:                     alu_a = rs1_data;
        endcase
    end
    assign alu_b = (opcode == OP_REG) ? rs2_data : imm;

    always_comb begin
        unique case (alu_op)
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << alu_b[4:0];
            ALU_SLT:  alu_result = {31'd0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'd0, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);                  // beq
            3'b001:  taken = (rs1_data != rs2_data);                  // bne
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  taken = (rs1_data < rs2_data);                   // bltu
            3'b111:  taken = (rs1_data >= rs2_data);                  // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign link = pc + 32'd4;

    always_comb begin
        if (opcode == OP_JAL || (opcode == OP_BRANCH && taken))
            next_pc = alu_result;
        else if (opcode == OP_JALR)
            next_pc = {alu_result[31:1], 1'b0};
        else
            next_pc = link;
    end

    assign exe_result = (opcode == OP_JAL || opcode == OP_JALR) ? link : alu_result;
    assign mem_addr   = rs1_data + imm;

endmodule

/* src/inst_decoder.sv */
/* Combinational RV32I decoder: instruction fields, immediate, ALU operation
   and the control flags used by the sequencer and load/store unit. */
`timescale 1ns/1ps

module inst_decoder (
    input  rv_core_pkg::word_t     inst,
    output rv_core_pkg::reg_addr_t rs1,
    output rv_core_pkg::reg_addr_t rs2,
    output rv_core_pkg::reg_addr_t rd,
    output rv_core_pkg::word_t     imm,
    output rv_core_pkg::funct3_t   funct3,
    output rv_core_pkg::alu_op_t   alu_op,
    output logic [6:0]             opcode,
    output logic                   reg_we,
    output logic                   mem_access,
    output logic                   is_load
);
    import rv_core_pkg::*;

    logic writes_rd;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // immediate format follows the opcode
    always_comb begin
        unique case (opcode)
            OP_IMM, OP_LOAD, OP_JALR:
                imm = {{20{inst[31]}}, inst[31:20]};
            OP_STORE:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OP_BRANCH:
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {inst[31:12], 12'h000};
            OP_JAL:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // everything outside OP_IMM/OP_REG is an add (addresses, targets, upper imm)
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OP_IMM || opcode == OP_REG) begin
            unique case (funct3)
                3'b000:  alu_op = (opcode == OP_REG && inst[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = inst[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    assign writes_rd = (opcode == OP_LUI) || (opcode == OP_AUIPC) || (opcode == OP_JAL)
                    || (opcode == OP_JALR) || (opcode == OP_LOAD) || (opcode == OP_IMM)
                    || (opcode == OP_REG);

    assign reg_we     = writes_rd && (rd != 5'd0);  // x0 writes dropped here
    assign is_load    = (opcode == OP_LOAD);
    assign mem_access = is_load || (opcode == OP_STORE);

endmodule

/* src/load_store_unit.sv */
/* Data memory port: issues one load or store per mem_start, aligns store data and mask
   to the byte lane, and extracts and extends load data from the response word. */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mem_start,
    input  logic                    is_load,
    input  rv_core_pkg::funct3_t    funct3,
    input  rv_core_pkg::word_t      mem_addr,
    input  rv_core_pkg::word_t      store_data,
    output logic                    dmem_req_valid,
    input  logic                    dmem_req_ready,
    output rv_core_pkg::word_t      dmem_addr,
    output logic                    dmem_we,
    output rv_core_pkg::byte_mask_t dmem_wmask,
    output rv_core_pkg::word_t      dmem_wdata,
    input  logic                    dmem_resp_valid,
    input  rv_core_pkg::word_t      dmem_resp_data,
    output logic                    mem_done,
    output rv_core_pkg::word_t      load_data
);
    import rv_core_pkg::*;

    logic       resp_wait;  // load accepted, response outstanding
    logic       req_fire;
    logic [1:0] offset;
    byte_mask_t base_mask;
    word_t      resp_shifted;

    assign req_fire = dmem_req_valid && dmem_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dmem_req_valid <= 1'b0;
            resp_wait      <= 1'b0;
        end else begin
            if (mem_start)
                dmem_req_valid <= 1'b1;
            else if (req_fire)
                dmem_req_valid <= 1'b0;
            if (req_fire && is_load)
                resp_wait <= 1'b1;
            else if (dmem_resp_valid)
                resp_wait <= 1'b0;
        end
    end

    // stores finish on the handshake, loads on the response
    assign mem_done = (req_fire && !is_load) || (resp_wait && dmem_resp_valid);

    // request fields hold steady, the core keeps inst and regs fixed in MEMORY
    assign offset    = mem_addr[1:0];
    assign dmem_addr = {mem_addr[31:2], 2'b00};
    assign dmem_we   = !is_load;

    always_comb begin
        unique case (funct3[1:0])
            2'b00:   base_mask = 4'h1;  // sb
            2'b01:   base_mask = 4'h3;  // sh
            default: base_mask = 4'hF;
        endcase
    end
    assign dmem_wmask = base_mask << offset;
    assign dmem_wdata = store_data << {offset, 3'b000};

    assign resp_shifted = dmem_resp_data >> {offset, 3'b000};

    always_comb begin
        unique case (funct3)
            3'b000:  load_data = {{24{resp_shifted[7]}}, resp_shifted[7:0]};    // lb
            3'b001:  load_data = {{16{resp_shifted[15]}}, resp_shifted[15:0]};  // lh
            3'b100:  load_data = {24'd0, resp_shifted[7:0]};                    // lbu
            3'b101:  load_data = {16'd0, resp_shifted[15:0]};                   // lhu
            default: load_data = resp_shifted;
        endcase
    end

endmodule

/* src/reg_file.sv */
/* General register file, 32 x 32 bits, two asynchronous read ports and one write port.
   x0 always reads as zero. */
`timescale 1ns/1ps

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::reg_addr_t raddr1,
    input  rv_core_pkg::reg_addr_t raddr2,
    output rv_core_pkg::word_t     rdata1,
    output rv_core_pkg::word_t     rdata2,
    input  logic                   we,
    input  rv_core_pkg::reg_addr_t waddr,
    input  rv_core_pkg::word_t     wdata
);
    import rv_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* src/rv_core.sv */
/* RV32I multicycle core top level with separate instruction and data memory ports
   and a retire port for checking. */
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    imem_req_valid,
    input  logic                    imem_req_ready,
    output rv_core_pkg::word_t      imem_addr,
    input  logic                    imem_resp_valid,
    input  rv_core_pkg::word_t      imem_resp_data,
    output logic                    dmem_req_valid,
    input  logic                    dmem_req_ready,
    output rv_core_pkg::word_t      dmem_addr,
    output logic                    dmem_we,
    output rv_core_pkg::byte_mask_t dmem_wmask,
    output rv_core_pkg::word_t      dmem_wdata,
    input  logic                    dmem_resp_valid,
    input  rv_core_pkg::word_t      dmem_resp_data,
    output logic                    retire_valid,
    output rv_core_pkg::word_t      retire_pc,
    output rv_core_pkg::reg_addr_t  retire_rd,
    output logic                    retire_we,
    output rv_core_pkg::word_t      retire_wdata
);
    import rv_core_pkg::*;

    word_t      inst, pc, imm, rs1_data, rs2_data;
    word_t      exe_result, next_pc, mem_addr, load_data, wb_data;
    reg_addr_t  rs1, rs2, rd, wb_addr;
    funct3_t    funct3;
    alu_op_t    alu_op;
    logic [6:0] opcode;
    logic       reg_we, mem_access, is_load;
    logic       mem_start, mem_done, wb_we;

    core_sequencer u_seq (
        .clk(clk), .reset(reset),
        .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
        .imem_addr(imem_addr), .imem_resp_valid(imem_resp_valid),
        .imem_resp_data(imem_resp_data),
        .mem_access(mem_access), .reg_we(reg_we), .rd(rd), .is_load(is_load),
        .exe_result(exe_result), .next_pc(next_pc), .inst(inst), .pc(pc),
        .mem_start(mem_start), .mem_done(mem_done), .load_data(load_data),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_wdata(retire_wdata)
    );

    inst_decoder u_dec (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .funct3(funct3),
        .alu_op(alu_op), .opcode(opcode), .reg_we(reg_we), .mem_access(mem_access),
        .is_load(is_load)
    );

    reg_file u_rf (
        .clk(clk), .reset(reset),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data),
        .we(wb_we), .waddr(wb_addr), .wdata(wb_data)
    );

    execute_unit u_exe (
        .opcode(opcode), .funct3(funct3), .alu_op(alu_op), .pc(pc), .imm(imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .exe_result(exe_result), .next_pc(next_pc), .mem_addr(mem_addr)
    );

    load_store_unit u_lsu (
        .clk(clk), .reset(reset),
        .mem_start(mem_start), .is_load(is_load), .funct3(funct3),
        .mem_addr(mem_addr), .store_data(rs2_data),
        .dmem_req_valid(dmem_req_valid), .dmem_req_ready(dmem_req_ready),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_resp_valid(dmem_resp_valid),
        .dmem_resp_data(dmem_resp_data), .mem_done(mem_done), .load_data(load_data)
    );

endmodule

/* src/rv_core_pkg.sv */
/* Shared widths, word types, opcode and ALU operation codes for the RV32I multicycle core.
   Imported by the core units and the testbench. */
package rv_core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   word_t;       // address or data word
    typedef logic [4:0]        reg_addr_t;   // x0..x31
    typedef logic [2:0]        funct3_t;
    typedef logic [XLEN/8-1:0] byte_mask_t;  // one enable per byte lane
    typedef logic [3:0]        alu_op_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // first fetch address out of reset
    localparam word_t RESET_PC = 32'h8000_0000;

endpackage

/* tb/rv_core_ref.svh */
/* Reference model for the core testbench, included in the testbench module body.
   Holds the RV32I encoders and a step function that predicts each retirement. */
`ifndef RV_CORE_REF_SVH
`define RV_CORE_REF_SVH

function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t enc_i(logic [6:0] op, logic [11:0] imm, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t enc_u(logic [6:0] op, logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, op};
endfunction

function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// byte address to testbench memory word
function automatic int word_index(word_t addr);
    return int'(addr[12:2]);
endfunction

// alt selects sub for funct3 0 and arithmetic shift for funct3 5
function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
        3'b000:  return alt ? x - y : x + y;
        3'b001:  return x << y[4:0];
        3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'b011:  return (x < y) ? 32'd1 : 32'd0;
        3'b100:  return x ^ y;
        3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'b110:  return x | y;
        default: return x & y;
    endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, word_t x, word_t y);
    case (f3)
        3'b000:  return x == y;
        3'b001:  return x != y;
        3'b100:  return $signed(x) < $signed(y);
        3'b101:  return $signed(x) >= $signed(y);
        3'b110:  return x < y;
        3'b111:  return x >= y;
        default: return 1'b0;
    endcase
endfunction

// runs the instruction at ref_pc on the model state
function automatic void ref_step(output word_t exp_pc, output logic exp_we,
                                 output reg_addr_t exp_rd, output word_t exp_wdata,
                                 output int store_idx);
    word_t      ins, a, b, res, nxt, addr, lw;
    logic [2:0] f3;
    logic       wr;
    int         k;
    ins = ref_mem[word_index(ref_pc)];
    f3  = ins[14:12];
    a   = ref_regs[ins[19:15]];
    b   = ref_regs[ins[24:20]];
    res = '0;
    nxt = ref_pc + 4;
    wr  = 1'b1;
    store_idx = -1;
    case (ins[6:0])
        OP_LUI:   res = {ins[31:12], 12'h000};
        OP_AUIPC: res = ref_pc + {ins[31:12], 12'h000};
        OP_JAL: begin
            res = ref_pc + 4;
            nxt = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        OP_JALR: begin
            res = ref_pc + 4;
            nxt = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
        end
        OP_BRANCH: begin
            wr = 1'b0;
            if (branch_taken(f3, a, b))
                nxt = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        OP_LOAD: begin
            addr = a + {{20{ins[31]}}, ins[31:20]};
            lw   = ref_mem[word_index(addr)] >> (8 * addr[1:0]);
            case (f3)
                3'b000:  res = {{24{lw[7]}}, lw[7:0]};
                3'b001:  res = {{16{lw[15]}}, lw[15:0]};
                3'b100:  res = {24'd0, lw[7:0]};
                3'b101:  res = {16'd0, lw[15:0]};
                default: res = lw;
            endcase
        end
        OP_STORE: begin
            wr        = 1'b0;
            addr      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            store_idx = word_index(addr);
            for (k = 0; k < (1 << f3[1:0]); k++)
                ref_mem[store_idx][8 * (addr[1:0] + k) +: 8] = b[8 * k +: 8];
        end
        OP_IMM:  res = alu_ref(f3, ins[30] && f3 == 3'b101, a, {{20{ins[31]}}, ins[31:20]});
        OP_REG:  res = alu_ref(f3, ins[30], a, b);
        default: wr = 1'b0;  // unsupported opcode
    endcase
    exp_pc    = ref_pc;
    exp_rd    = ins[11:7];
    exp_we    = wr && (exp_rd != 5'd0);
    exp_wdata = res;
    if (exp_we)
        ref_regs[exp_rd] = res;
    ref_pc = nxt;
endfunction

`endif

/* tb/rv_core_tb.sv */
/* Testbench for the RV32I core: builds a random program, serves both memory ports with
   random stalls and delays, and checks every retirement against the reference model. */
`timescale 1ns/1ps

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int NUM_INST   = 60;
    localparam int MAX_CYCLES = NUM_INST * 20;
    localparam int MEM_WORDS  = 2048;  // 8 KB, code at the base, data near +4 KB

    logic       clk = 1'b0;
    logic       reset;
    logic       imem_req_valid, imem_req_ready, imem_resp_valid;
    word_t      imem_addr, imem_resp_data;
    logic       dmem_req_valid, dmem_req_ready, dmem_we, dmem_resp_valid;
    word_t      dmem_addr, dmem_wdata, dmem_resp_data;
    byte_mask_t dmem_wmask;
    logic       retire_valid, retire_we;
    word_t      retire_pc, retire_wdata;
    reg_addr_t  retire_rd;

    word_t      mem [MEM_WORDS];      // serves both ports
    word_t      ref_mem [MEM_WORDS];
    word_t      ref_regs [32];
    word_t      ref_pc, end_pc;
    int         prog_len, loop_count, cycles;
    int         i_wait, d_wait;       // response countdowns
    word_t      i_addr, d_addr;
    logic       i_hold, d_hold;       // request stalled at the last edge
    word_t      i_hold_addr, d_hold_addr, d_hold_wdata;
    logic       d_hold_we;
    byte_mask_t d_hold_mask;

    `include "rv_core_ref.svh"

    rv_core UUT (
        .clk(clk), .reset(reset),
        .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
        .imem_addr(imem_addr), .imem_resp_valid(imem_resp_valid),
        .imem_resp_data(imem_resp_data),
        .dmem_req_valid(dmem_req_valid), .dmem_req_ready(dmem_req_ready),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_resp_valid(dmem_resp_valid),
        .dmem_resp_data(dmem_resp_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_wdata(retire_wdata)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_failure(input string why);
        $display("ERROR at %0t: %s", $time, why);
        stop_on_error();
    endtask

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        stop_on_error();
    endtask

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic reg_addr_t pick_rd();
        word_t rnd;
        rnd = $urandom;
        return (rnd[4:0] == 5'd1) ? 5'd0 : rnd[4:0];  // x1 keeps the data base
    endfunction

    function automatic reg_addr_t pick_src();
        word_t rnd;
        rnd = $urandom;
        return rnd[4:0];
    endfunction

    // byte offset aligned to the access width
    function automatic logic [11:0] lane_offset(logic [2:0] f3);
        word_t rnd;
        rnd = $urandom;
        case (f3[1:0])
            2'b00:   return {10'd0, rnd[1:0]};
            2'b01:   return {10'd0, rnd[0], 1'b0};
            default: return 12'd0;
        endcase
    endfunction

    task automatic put_inst(input word_t w);
        mem[word_index(RESET_PC) + prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        word_t       rnd;
        logic [2:0]  f3, lf3;
        logic [11:0] imm, base;
        int          sel;
        prog_len = 0;
        put_inst(enc_u(OP_LUI, 20'h80001, 5'd1));  // data base in x1
        put_inst(enc_i(OP_IMM, 12'h123, 5'd0, 3'b000, 5'd0));
        put_inst({25'h1ABCDE5, 7'b0001011});      // custom-0, unsupported
        while (prog_len < NUM_INST - 4) begin
            rnd = $urandom;
            f3  = rnd[14:12];
            case ($urandom_range(0, 11))
                0: put_inst(enc_u(OP_LUI, rnd[31:12], pick_rd()));
                1: put_inst(enc_u(OP_AUIPC, rnd[31:12], pick_rd()));
                2, 3: begin
                    if (f3 == 3'b001)
                        imm = {7'd0, rnd[4:0]};
                    else if (f3 == 3'b101)
                        imm = {1'b0, rnd[5], 5'd0, rnd[4:0]};  // srli or srai
                    else
                        imm = rnd[31:20];
                    put_inst(enc_i(OP_IMM, imm, pick_src(), f3, pick_rd()));
                end
                4, 5: put_inst(enc_r(((f3 == 3'b000 || f3 == 3'b101) && rnd[0]) ? 7'h20 : 7'h00,
                                     pick_src(), pick_src(), f3, pick_rd()));
                6: begin
                    if (f3[2:1] == 2'b01)
                        f3[2] = 1'b1;  // only the six valid conditions
                    put_inst(enc_b(13'd8, pick_src(), pick_src(), f3));
                    put_inst(enc_i(OP_IMM, rnd[31:20], pick_src(), 3'b000, pick_rd()));
                end
                7: begin
                    put_inst(enc_j(21'd8, pick_rd()));
                    put_inst(enc_i(OP_IMM, rnd[31:20], pick_src(), 3'b000, pick_rd()));
                end
                8: begin
                    put_inst(enc_u(OP_AUIPC, 20'd0, 5'd2));
                    put_inst(enc_i(OP_JALR, 12'd12, 5'd2, 3'b000, pick_rd()));
                    put_inst(enc_i(OP_IMM, rnd[31:20], pick_src(), 3'b000, pick_rd()));
                end
                9, 10: begin
                    base = {{5{rnd[4]}}, rnd[4:0], 2'b00};
                    sel  = $urandom_range(0, 2);
                    f3   = sel[2:0];
                    sel  = $urandom_range(0, 4);
                    lf3  = (sel > 2) ? sel[2:0] + 3'd1 : sel[2:0];  // lb lh lw lbu lhu
                    put_inst(enc_s(base + lane_offset(f3), pick_src(), 5'd1, f3));
                    put_inst(enc_i(OP_LOAD, base + lane_offset(lf3), 5'd1, lf3, pick_rd()));
                end
                default: put_inst({rnd[31:7], 7'b0001011});
            endcase
        end
        put_inst(enc_j(21'd0, 5'd0));  // final self loop
        end_pc = RESET_PC + 4 * (prog_len - 1);
    endtask

    // memory model drives its responses and random ready on the falling edge
    always @(negedge clk) begin
        imem_req_ready  = ($urandom_range(0, 99) >= 30);
        dmem_req_ready  = ($urandom_range(0, 99) >= 30);
        imem_resp_valid = 1'b0;
        dmem_resp_valid = 1'b0;
        if (i_wait > 0) begin
            i_wait--;
            if (i_wait == 0) begin
                imem_resp_valid = 1'b1;
                imem_resp_data  = mem[word_index(i_addr)];
            end
        end
        if (d_wait > 0) begin
            d_wait--;
            if (d_wait == 0) begin
                dmem_resp_valid = 1'b1;
                dmem_resp_data  = mem[word_index(d_addr)];
            end
        end
    end

    // handshakes, stall stability and retire checks at the rising edge
    always @(posedge clk) begin : retire_monitor
        word_t     exp_pc, exp_wdata;
        reg_addr_t exp_rd;
        logic      exp_we;
        int        st_idx, k;
        cycles++;
        if (cycles > MAX_CYCLES)
            report_failure("timeout, the program never reached its final loop");
        if (reset) begin
            if (cycles > 1)
                assert (!retire_valid && !imem_req_valid && !dmem_req_valid)
                    else report_failure("a valid output was high during reset");
        end else begin
            if (i_hold)
                assert (imem_req_valid && imem_addr == i_hold_addr)
                    else report_failure("instruction request changed while stalled");
            if (d_hold)
                assert (dmem_req_valid && dmem_addr == d_hold_addr && dmem_we == d_hold_we
                        && dmem_wmask == d_hold_mask && dmem_wdata == d_hold_wdata)
                    else report_failure("data request changed while stalled");
            i_hold       = imem_req_valid && !imem_req_ready;
            i_hold_addr  = imem_addr;
            d_hold       = dmem_req_valid && !dmem_req_ready;
            d_hold_addr  = dmem_addr;
            d_hold_we    = dmem_we;
            d_hold_mask  = dmem_wmask;
            d_hold_wdata = dmem_wdata;
            if (imem_req_valid && imem_req_ready) begin
                i_addr = imem_addr;
                i_wait = $urandom_range(1, 4);
            end
            if (dmem_req_valid && dmem_req_ready) begin
                if (dmem_we) begin
                    for (k = 0; k < 4; k++)
                        if (dmem_wmask[k])
                            mem[word_index(dmem_addr)][8 * k +: 8] = dmem_wdata[8 * k +: 8];
                end else begin
                    d_addr = dmem_addr;
                    d_wait = $urandom_range(1, 4);
                end
            end
            if (retire_valid) begin
                ref_step(exp_pc, exp_we, exp_rd, exp_wdata, st_idx);
                assert (retire_pc == exp_pc)
                    else report_mismatch("retire_pc", exp_pc, retire_pc);
                assert (retire_we == exp_we)
                    else report_mismatch("retire_we", {31'd0, exp_we}, {31'd0, retire_we});
                if (exp_we) begin
                    assert (retire_rd == exp_rd)
                        else report_mismatch("retire_rd", {27'd0, exp_rd}, {27'd0, retire_rd});
                    assert (retire_wdata == exp_wdata)
                        else report_mismatch("retire_wdata", exp_wdata, retire_wdata);
                end
                if (st_idx >= 0)  // store landed with the right byte mask
                    assert (mem[st_idx] == ref_mem[st_idx])
                        else report_mismatch("dmem word", ref_mem[st_idx], mem[st_idx]);
                if (exp_pc == end_pc)
                    loop_count++;
            end
        end
    end

    initial begin
        int i;
        void'($urandom(64806));
        reset           = 1'b1;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        dmem_req_ready  = 1'b0;
        dmem_resp_valid = 1'b0;
        dmem_resp_data  = '0;
        i_wait     = 0;
        d_wait     = 0;
        i_hold     = 1'b0;
        d_hold     = 1'b0;
        cycles     = 0;
        loop_count = 0;
        for (i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(RESET_PC + 4 * i);
        build_program();
        ref_mem = mem;
        ref_pc  = RESET_PC;
        for (i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        wait (loop_count == 2);  // self loop retired twice
        @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule
